// File: stat_defines.svh
`ifndef STAT_DEFINES_SVH
`define STAT_DEFINES_SVH

// Number of per-channel counters
`define STAT_NUM_CHAN 32

// Register file address, wide enough for every channel
`define STAT_ADDR_W 5

// Counter and host data word
`define STAT_CNT_W 32

// Byte count carried by one packet event
`define STAT_BYTES_W 16

`endif

// File: stat_pkg.sv
package stat_pkg;

`include "stat_defines.svh"

    // Channel number, also the register file address
    typedef logic [`STAT_ADDR_W-1:0] chan_t;

    // Counter value and host data word
    typedef logic [`STAT_CNT_W-1:0] cnt_t;

    // Byte count of one event
    typedef logic [`STAT_BYTES_W-1:0] bytes_t;

    // Host port sequencing
    typedef enum logic [1:0]
    {
        idle,
        strobe,
        wait_rdy
    } host_state_t;

endpackage

// File: stat_regfile.sv
`timescale 1ns/1ps

`include "stat_defines.svh"

module stat_regfile
    import stat_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  memwe,
    input  chan_t memwa,
    input  cnt_t  memwrd,
    input  logic  memre,
    input  chan_t memra,
    output cnt_t  memrdd
);

    cnt_t  mem [`STAT_NUM_CHAN];
    logic  clr_busy;
    chan_t clr_idx;

    // Clear walk, one counter per cycle after reset
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            clr_busy <= 1'b1;
            clr_idx  <= '0;
        end
        else if (clr_busy)
        begin
            clr_idx <= clr_idx + 1'b1;
            // Last channel done
            if (clr_idx == chan_t'(`STAT_NUM_CHAN - 1))
                clr_busy <= 1'b0;
        end
    end

    // Write port, the clear walk owns it until finished
    always_ff @(posedge clk)
    begin
        if (clr_busy)
            mem[clr_idx] <= '0;
        else if (memwe)
            mem[memwa] <= memwrd;
    end

    // Registered read, holds the last word between reads
    always_ff @(posedge clk)
    begin
        if (memre)
            memrdd <= mem[memra];
    end

    // Arbiter must mask a read hitting the address being written
    assert property (@(posedge clk) disable iff (rst)
        !(memwe && memre && (memwa == memra)))
        else $error("regfile read and write on the same address");

endmodule

// File: stat_ram_arbiter.sv
`timescale 1ns/1ps

module stat_ram_arbiter
    import stat_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    // Engine side
    input  logic  eng_re,
    input  chan_t eng_ra,
    output cnt_t  eng_rdd,
    input  logic  eng_we,
    input  chan_t eng_wa,
    input  cnt_t  eng_wrd,

    // Host side
    input  logic  upen,
    input  logic  upws,
    input  logic  uprs,
    input  chan_t upa,
    input  cnt_t  updi,
    output cnt_t  updo,
    output logic  uprdy,

    // Count enable level
    input  logic  count_en,

    // Register file side
    output logic  memwe,
    output logic  memre,
    output chan_t memwa,
    output chan_t memra,
    output cnt_t  memwrd,
    input  cnt_t  memrdd
);

    //////////////////////////////////////////////////////////////////////
    // Request qualification

    logic  eng_wr;
    logic  eng_rd;
    logic  up_wr;
    logic  up_rd;
    logic  upwr_lat;
    logic  uprd_lat;
    logic  upwr_ok;
    logic  uprd_ok;

    // Engine strobes only count while enabled
    assign eng_wr = eng_we & count_en;
    assign eng_rd = eng_re & count_en;

    // Host strobes only inside an open access
    assign up_wr = upws & upen;
    assign up_rd = uprs & upen;

    // Host wins a port only when the engine leaves it free
    assign upwr_ok = upwr_lat & ~eng_wr;
    assign uprd_ok = uprd_lat & ~eng_rd;

    // Pending host requests dropped when the access closes
    always_ff @(posedge clk)
    begin
        if (rst || !upen)
        begin
            upwr_lat <= 1'b0;
            uprd_lat <= 1'b0;
        end
        else
        begin
            if (upwr_ok)
                upwr_lat <= 1'b0;
            else if (up_wr)
                upwr_lat <= 1'b1;

            if (uprd_ok)
                uprd_lat <= 1'b0;
            else if (up_rd)
                uprd_lat <= 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Shared port muxing and bypass

    logic  ram_we;
    chan_t ram_wa;
    cnt_t  ram_wrd;
    logic  ram_re;
    chan_t ram_ra;
    logic  wr_conflict;
    logic  same_stage1;
    cnt_t  ram_wrd1;

    // Engine first on both ports
    assign ram_we  = eng_wr | upwr_lat;
    assign ram_wa  = eng_wr ? eng_wa : upa;
    assign ram_wrd = eng_wr ? eng_wrd : updi;
    assign ram_re  = eng_rd | uprd_lat;
    assign ram_ra  = eng_rd ? eng_ra : upa;

    // Read and write on one address in the same cycle
    assign wr_conflict = ram_we & (ram_wa == ram_ra);

    always_ff @(posedge clk)
    begin
        if (rst)
            same_stage1 <= 1'b0;
        else
            same_stage1 <= ram_re & wr_conflict;
    end

    // Written word kept one cycle for the bypass
    always_ff @(posedge clk)
    begin
        ram_wrd1 <= ram_wrd;
    end

    // Fresh write data replaces the masked read
    assign eng_rdd = same_stage1 ? ram_wrd1 : memrdd;

    assign memwe  = ram_we;
    assign memwa  = ram_wa;
    assign memwrd = ram_wrd;
    assign memre  = ram_re & ~wr_conflict;
    assign memra  = ram_ra;

    //////////////////////////////////////////////////////////////////////
    // Host completion

    logic acc_ok;
    logic acc_ok1;
    logic acc_ok2;
    cnt_t eng_rdd1;

    assign acc_ok = upwr_ok | uprd_ok;

    // Take plus two cycles gives ready
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            acc_ok1 <= 1'b0;
            acc_ok2 <= 1'b0;
        end
        else
        begin
            acc_ok1 <= acc_ok;
            acc_ok2 <= acc_ok1;
        end
    end

    // Read data lines up with ready
    always_ff @(posedge clk)
    begin
        eng_rdd1 <= eng_rdd;
    end

    assign uprdy = acc_ok2;
    assign updo  = upen ? eng_rdd1 : '0;

    // Host port keeps upen up until ready arrives
    assert property (@(posedge clk) disable iff (rst) uprdy |-> upen)
        else $error("uprdy outside a host access");

    // A pending request would be dropped if upen fell before the take
    assert property (@(posedge clk) disable iff (rst)
        (upwr_lat || uprd_lat) |=> upen)
        else $error("upen dropped with a host request pending");

endmodule

// File: stat_update_engine.sv
`timescale 1ns/1ps

`include "stat_defines.svh"

module stat_update_engine
    import stat_pkg::*;
(
    input  logic   clk,
    input  logic   rst,

    // Packet events
    input  logic   evt_valid,
    input  chan_t  evt_chan,
    input  bytes_t evt_bytes,

    // Counter read
    output logic   eng_re,
    output chan_t  eng_ra,
    input  cnt_t   eng_rdd,

    // Counter write back
    output logic   eng_we,
    output chan_t  eng_wa,
    output cnt_t   eng_wrd
);

    //////////////////////////////////////////////////////////////////////
    // Stage one

    logic   s1_valid;
    chan_t  s1_chan;
    bytes_t s1_bytes;

    // Read issued in the event cycle
    assign eng_re = evt_valid;
    assign eng_ra = evt_chan;

    // Event flag tracked with reset
    always_ff @(posedge clk)
    begin
        if (rst)
            s1_valid <= 1'b0;
        else
            s1_valid <= evt_valid;
    end

    // Event payload follows the read
    always_ff @(posedge clk)
    begin
        s1_chan  <= evt_chan;
        s1_bytes <= evt_bytes;
    end

    //////////////////////////////////////////////////////////////////////
    // Stage two

    cnt_t add_bytes;

    // Byte count widened to the counter
    assign add_bytes = {{(`STAT_CNT_W - `STAT_BYTES_W){1'b0}}, s1_bytes};

    // Write back one cycle after the read
    assign eng_we = s1_valid;
    assign eng_wa = s1_chan;

    // Sum wraps at the counter width
    // eng_rdd already holds bypassed data for back to back hits
    assign eng_wrd = eng_rdd + add_bytes;

endmodule

// File: stat_host_port.sv
`timescale 1ns/1ps

module stat_host_port
    import stat_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    // Host bus
    input  logic  host_req,
    input  logic  host_we,
    input  chan_t host_addr,
    input  cnt_t  host_wdata,
    output logic  host_ack,
    output cnt_t  host_rdata,

    // Arbiter host side
    output logic  upen,
    output logic  upws,
    output logic  uprs,
    output chan_t upa,
    output cnt_t  updi,
    input  cnt_t  updo,
    input  logic  uprdy
);

    host_state_t state;
    logic        we_q;
    chan_t       addr_q;
    cnt_t        wdata_q;

    // Access FSM
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state    <= idle;
            host_ack <= 1'b0;
        end
        else
        begin
            host_ack <= 1'b0;
            case (state)
                // New requests only here
                idle:
                    if (host_req)
                        state <= strobe;
                // Single strobe cycle
                strobe:
                    state <= wait_rdy;
                wait_rdy:
                    if (uprdy)
                    begin
                        state    <= idle;
                        host_ack <= 1'b1;
                    end
                default:
                    state <= idle;
            endcase
        end
    end

    // Request captured and held for the whole access
    always_ff @(posedge clk)
    begin
        if (state == idle && host_req)
        begin
            we_q    <= host_we;
            addr_q  <= host_addr;
            wdata_q <= host_wdata;
        end
    end

    // Result word is zero after a write
    always_ff @(posedge clk)
    begin
        if (state == wait_rdy && uprdy)
            host_rdata <= we_q ? '0 : updo;
    end

    assign upen = (state != idle);
    assign upws = (state == strobe) & we_q;
    assign uprs = (state == strobe) & ~we_q;
    assign upa  = addr_q;
    assign updi = wdata_q;

    // Arbiter ready only ends an access that was strobed
    assert property (@(posedge clk) disable iff (rst)
        uprdy |-> (state == wait_rdy))
        else $error("uprdy outside the wait state");

endmodule

// File: stat_counter_top.sv
`timescale 1ns/1ps

module stat_counter_top
    import stat_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   count_en,

    // Packet events
    input  logic   evt_valid,
    input  chan_t  evt_chan,
    input  bytes_t evt_bytes,

    // Host bus
    input  logic   host_req,
    input  logic   host_we,
    input  chan_t  host_addr,
    input  cnt_t   host_wdata,
    output logic   host_ack,
    output cnt_t   host_rdata
);

    //////////////////////////////////////////////////////////////////////
    // Engine to arbiter
    logic  eng_re;
    chan_t eng_ra;
    cnt_t  eng_rdd;
    logic  eng_we;
    chan_t eng_wa;
    cnt_t  eng_wrd;

    // Host port to arbiter
    logic  upen;
    logic  upws;
    logic  uprs;
    chan_t upa;
    cnt_t  updi;
    cnt_t  updo;
    logic  uprdy;

    // Arbiter to register file
    logic  memwe;
    logic  memre;
    chan_t memwa;
    chan_t memra;
    cnt_t  memwrd;
    cnt_t  memrdd;

    stat_update_engine stat_update_engine_i (
        .clk       (clk),
        .rst       (rst),
        .evt_valid (evt_valid),
        .evt_chan  (evt_chan),
        .evt_bytes (evt_bytes),
        .eng_re    (eng_re),
        .eng_ra    (eng_ra),
        .eng_rdd   (eng_rdd),
        .eng_we    (eng_we),
        .eng_wa    (eng_wa),
        .eng_wrd   (eng_wrd)
    );

    stat_host_port stat_host_port_i (
        .clk        (clk),
        .rst        (rst),
        .host_req   (host_req),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_ack   (host_ack),
        .host_rdata (host_rdata),
        .upen       (upen),
        .upws       (upws),
        .uprs       (uprs),
        .upa        (upa),
        .updi       (updi),
        .updo       (updo),
        .uprdy      (uprdy)
    );

    stat_ram_arbiter stat_ram_arbiter_i (
        .clk      (clk),
        .rst      (rst),
        .eng_re   (eng_re),
        .eng_ra   (eng_ra),
        .eng_rdd  (eng_rdd),
        .eng_we   (eng_we),
        .eng_wa   (eng_wa),
        .eng_wrd  (eng_wrd),
        .upen     (upen),
        .upws     (upws),
        .uprs     (uprs),
        .upa      (upa),
        .updi     (updi),
        .updo     (updo),
        .uprdy    (uprdy),
        .count_en (count_en),
        .memwe    (memwe),
        .memre    (memre),
        .memwa    (memwa),
        .memra    (memra),
        .memwrd   (memwrd),
        .memrdd   (memrdd)
    );

    stat_regfile stat_regfile_i (
        .clk    (clk),
        .rst    (rst),
        .memwe  (memwe),
        .memwa  (memwa),
        .memwrd (memwrd),
        .memre  (memre),
        .memra  (memra),
        .memrdd (memrdd)
    );

endmodule

// File: tb_stat_counter.sv
`timescale 1ns/1ps

`include "stat_defines.svh"

module tb_stat_counter
    import stat_pkg::*;
();

    logic   clk;
    logic   rst;
    logic   count_en;
    logic   evt_valid;
    chan_t  evt_chan;
    bytes_t evt_bytes;
    logic   host_req;
    logic   host_we;
    chan_t  host_addr;
    cnt_t   host_wdata;
    logic   host_ack;
    cnt_t   host_rdata;

    // Expected counter contents
    cnt_t        model [`STAT_NUM_CHAN];
    logic [15:0] lfsr_state;

    localparam int ACK_TIMEOUT = 500;
    localparam int CLEAR_TRIES = 20;

    stat_counter_top stat_counter_top_i (
        .clk        (clk),
        .rst        (rst),
        .count_en   (count_en),
        .evt_valid  (evt_valid),
        .evt_chan   (evt_chan),
        .evt_bytes  (evt_bytes),
        .host_req   (host_req),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_ack   (host_ack),
        .host_rdata (host_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #20 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Random source and checks

    // 16-bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_cnt(input string name, input cnt_t exp, input cnt_t act);
        if (act !== exp)
            abort_run($sformatf("MISMATCH %s expected %08h actual %08h", name, exp, act));
    endtask

    task automatic check_chan(input string name, input chan_t exp, input chan_t act);
        if (act !== exp)
            abort_run($sformatf("MISMATCH %s expected %0d actual %0d", name, exp, act));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Bus drivers

    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #2;
        end
    endtask

    // One host request returning the word that comes with the ack
    task automatic host_access(input logic we, input chan_t addr, input cnt_t wdata,
                               output cnt_t rdata);
        int waited;
        host_req   = 1'b1;
        host_we    = we;
        host_addr  = addr;
        host_wdata = wdata;
        @(posedge clk);
        #2;
        host_req = 1'b0;
        waited   = 0;
        // Ack and data are registered and settled by the falling edge
        @(negedge clk);
        while (host_ack !== 1'b1 && waited < ACK_TIMEOUT)
        begin
            waited++;
            @(negedge clk);
        end
        if (host_ack !== 1'b1)
            abort_run($sformatf("host access to channel %0d got no acknowledge", addr));
        rdata = host_rdata;
        @(posedge clk);
        #2;
    endtask

    task automatic host_read(input chan_t addr, output cnt_t data);
        host_access(1'b0, addr, '0, data);
    endtask

    // Write also checks the zero data word returned with its ack
    task automatic host_write(input string name, input chan_t addr, input cnt_t data);
        cnt_t rd;
        host_access(1'b1, addr, data, rd);
        check_cnt({name, " write ack data"}, '0, rd);
        model[addr] = data;
    endtask

    // One cycle event strobe that the model counts only when enabled
    task automatic send_event(input chan_t ch, input bytes_t nbytes);
        evt_valid = 1'b1;
        evt_chan  = ch;
        evt_bytes = nbytes;
        if (count_en)
            model[ch] = model[ch] + cnt_t'(nbytes);
        @(posedge clk);
        #2;
        evt_valid = 1'b0;
    endtask

    task automatic verify_all(input string name);
        cnt_t rd;
        int   ch;
        for (ch = 0; ch < `STAT_NUM_CHAN; ch++)
        begin
            host_read(chan_t'(ch), rd);
            check_cnt(name, model[ch], rd);
        end
    endtask

    // Clear walk needs one cycle per channel and ends on the last one
    task automatic wait_clear();
        cnt_t rd;
        int   tries;
        rd    = '1;
        tries = 0;
        idle_cycles(`STAT_NUM_CHAN);
        while (rd !== '0 && tries < CLEAR_TRIES)
        begin
            host_read(chan_t'(`STAT_NUM_CHAN - 1), rd);
            tries++;
        end
        if (rd !== '0)
            abort_run("register file clear did not finish after reset");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests

    task automatic reset_reads_zero();
        verify_all("reset_reads_zero");
    endtask

    task automatic write_read_back();
        cnt_t        rd;
        cnt_t        data;
        logic [31:0] r;
        int          ch;
        for (ch = 0; ch < `STAT_NUM_CHAN; ch++)
        begin
            // Low bits echo the channel number
            r    = rand_bits(27);
            data = {r[26:0], chan_t'(ch)};
            host_write("write_read_back", chan_t'(ch), data);
            host_read(chan_t'(ch), rd);
            check_chan("write_read_back addr echo", chan_t'(ch), chan_t'(rd));
            check_cnt("write_read_back", data, rd);
        end
    endtask

    task automatic single_events();
        cnt_t        rd;
        logic [31:0] r;
        chan_t       ch;
        int          k;
        for (k = 0; k < 8; k++)
        begin
            r  = rand_bits(21);
            ch = r[20:16];
            send_event(ch, r[15:0]);
            idle_cycles(3);
            host_read(ch, rd);
            check_cnt("single_events", model[ch], rd);
        end
        // Wraps modulo 2^32
        host_write("single_events wrap", 5'd9, 32'hFFFF_FFF0);
        send_event(5'd9, 16'h0025);
        idle_cycles(3);
        host_read(5'd9, rd);
        check_cnt("single_events wrap", 32'h0000_0015, rd);
    endtask

    task automatic back_to_back_events();
        cnt_t        rd;
        logic [31:0] r;
        int          k;
        // Run of ten hits the bypass every cycle
        for (k = 0; k < 10; k++)
        begin
            r = rand_bits(16);
            send_event(5'd12, r[15:0]);
        end
        idle_cycles(3);
        host_read(5'd12, rd);
        check_cnt("back_to_back run", model[12], rd);
        // Alternating pair hits each channel every other cycle
        for (k = 0; k < 12; k++)
            send_event((k % 2) ? 5'd3 : 5'd4, bytes_t'(16'h0100 + k));
        // Run across the wrap point
        host_write("back_to_back wrap", 5'd0, 32'hFFFF_0000);
        for (k = 0; k < 10; k++)
            send_event(5'd0, 16'hFFFF);
        idle_cycles(3);
        verify_all("back_to_back_events");
    endtask

    task automatic count_disable();
        cnt_t rd;
        int   k;
        idle_cycles(2);
        count_en = 1'b0;
        for (k = 0; k < 4; k++)
            send_event(5'd20, 16'h1234);
        idle_cycles(2);
        count_en = 1'b1;
        host_read(5'd20, rd);
        check_cnt("count_disable off", model[20], rd);
        // Counting resumes
        send_event(5'd20, 16'h0042);
        idle_cycles(3);
        host_read(5'd20, rd);
        check_cnt("count_disable on", model[20], rd);
    endtask

    task automatic burst_with_host_reads();
        chan_t       rd_chan [6];
        logic [31:0] ra;
        logic [31:0] rv;
        cnt_t        got;
        int          ka;
        int          kb;
        for (kb = 0; kb < 6; kb++)
        begin
            ra = rand_bits(4);
            rd_chan[kb] = {1'b1, ra[3:0]};
        end
        fork
            // Random events on the lower half of the channels
            begin
                for (ka = 0; ka < 120; ka++)
                begin
                    rv = rand_bits(1);
                    if (rv[0])
                    begin
                        ra = rand_bits(20);
                        send_event({1'b0, ra[3:0]}, ra[19:4]);
                    end
                    else
                        idle_cycles(1);
                end
            end
            // Host reads of the untouched upper half
            begin
                for (kb = 0; kb < 6; kb++)
                begin
                    host_read(rd_chan[kb], got);
                    check_cnt("burst host read", model[rd_chan[kb]], got);
                end
            end
        join
        idle_cycles(3);
        verify_all("burst drained");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Sequence

    initial
    begin
        int ch;
        rst        = 1'b1;
        count_en   = 1'b1;
        evt_valid  = 1'b0;
        evt_chan   = '0;
        evt_bytes  = '0;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        lfsr_state = 16'd61473;
        for (ch = 0; ch < `STAT_NUM_CHAN; ch++)
            model[ch] = '0;

        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        wait_clear();

        reset_reads_zero();
        write_read_back();
        single_events();
        back_to_back_events();
        count_disable();
        burst_with_host_reads();

        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: build.f
+incdir+.
stat_pkg.sv
stat_regfile.sv
stat_ram_arbiter.sv
stat_update_engine.sv
stat_host_port.sv
stat_counter_top.sv
tb_stat_counter.sv

// File: Bender.yml
package:
  name: stat_counter

export_include_dirs:
  - .

sources:
  - stat_pkg.sv
  - stat_regfile.sv
  - stat_ram_arbiter.sv
  - stat_update_engine.sv
  - stat_host_port.sv
  - stat_counter_top.sv
  - target: test
    files:
      - tb_stat_counter.sv
